//--- common/rom_share_pkg.sv
package rom_share_pkg;

	// ==================================================
	// Bus widths
	// ==================================================
	localparam int ROM_AW = 19;
	localparam int CPU_AW = 16;
	localparam int GFX_AW = 12;
	localparam int BYTE_W = 8;
	// Configuration address counter
	localparam int CFG_AW = 13;

	// Region nibbles, sit just above the 12-bit graphics address
	localparam logic [3:0] TILE1_BASE = 4'h6;
	localparam logic [3:0] TILE2_BASE = 4'h7;
	localparam logic [3:0] OBJ1_BASE  = 4'hA;
	localparam logic [3:0] OBJ2_BASE  = 4'hB;
	localparam logic [3:0] OBJ3_BASE  = 4'hC;
	localparam logic [3:0] OBJ4_BASE  = 4'hD;

	// ==================================================
	// Slot schedule
	// ==================================================
	typedef enum logic [3:0] {
		SLOT_WAVE, SLOT_CPU, SLOT_TILE1, SLOT_TILE2,
		SLOT_OBJ1, SLOT_OBJ2, SLOT_OBJ3, SLOT_OBJ4, SLOT_IDLE
	} slot_e;
	localparam int PHASES = 16;

	// Start-up configuration copy
	localparam logic [CFG_AW-1:0] CONF_LAST = 13'h12FF;
	// Top address bit, clear for the sound table
	localparam logic       CONF_SOUND_TOP = 1'b0;
	// Codes of address bits 12..8
	localparam logic [4:0] CONF_COL0 = 5'h10;
	localparam logic [4:0] CONF_COL1 = 5'h11;
	localparam logic [4:0] CONF_VRAM = 5'h12;
	typedef enum logic [1:0] {CFG_SOUND, CFG_COL0, CFG_COL1, CFG_VRAM} cfg_target_e;

	// ==================================================
	// Wave sounds
	// ==================================================
	typedef enum logic [1:0] {WALK, JUMP, LAND, FALL} WAVE_BASE_e;
	// Walk entry gets the multi-sample offset added on top
	localparam logic [15:0] WAVE_START [4] = '{16'h0000, 16'h3000, 16'h5000, 16'h7000};
	localparam logic [15:0] WAVE_LEN   [4] = '{16'h0800, 16'h2000, 16'h2000, 16'h5000};
	// Walk and climb step pattern
	localparam logic [2:0] MSAMPLE_SEQ [7] = '{3'd1, 3'd2, 3'd1, 3'd2, 3'd0, 3'd1, 3'd0};

	// Mixer limits, 9-bit sum domain
	localparam logic [8:0] MIX_HI = 9'h17F;
	localparam logic [8:0] MIX_LO = 9'h080;

endpackage

//--- dv/rom_sound_cases.txt
# kind name arg0 arg1 expected, numbers in hex
# cfg: expected strobe count; cpu: arg0 cpu_addr; gfx: arg0 plane 1..6, arg1 address
# mix: arg0 digital_data; walk: arg0 walk_alt; jump, fall: expected start address
cfg config_load 0 0 28
cpu bank02_remap 1123 0 12
cpu bank03_remap 1923 0 7A
cpu bank05_remap 2923 0 6A
cpu bank06_remap 3123 0 32
cpu bank07_remap 3923 0 3A
cpu bank09_remap 4923 0 0A
cpu bank0b_remap 5923 0 1A
cpu bank04_pass 2123 0 02
gfx tile_plane1 1 5A3 C6
gfx tile_plane2 2 5A3 D6
gfx obj_plane1 3 3C1 62
gfx obj_plane2 4 3C1 72
gfx obj_plane3 5 3C1 02
gfx obj_plane4 6 3C1 12
mix top_clip FF 0 FF
mix near_top FE 0 FE
mix bottom_clip 00 0 00
mix near_bottom 01 0 01
mix mid_low 40 0 40
mix mid_high C0 0 C0
walk walk_alt_1 1 0 0800
walk walk_alt_2 1 0 1000
walk walk_alt_3 1 0 0800
walk walk_alt_4 1 0 1000
walk climb_1 0 0 1800
walk climb_2 0 0 2000
walk climb_3 0 0 1800
walk climb_4 0 0 2000
jump jump_start 0 0 3000
fall fall_start 0 0 7000

//--- dv/rom_sound_properties.sv
`timescale 1ns/1ns

module rom_sound_properties import rom_share_pkg::*; (
	input logic              W_CLK_12288M,
	input logic              I_RESETn,
	input logic [3:0]        phase,
	input logic [ROM_AW-1:0] rom_addr,
	input logic              cfg_active,
	input logic              frame_end
);

	// ==================================================
	// Graphics region nibbles follow the slot table
	// ==================================================
	// Address issued in one phase sits on rom_addr in the next
	a_tile1_region: assert property (@(posedge W_CLK_12288M) disable iff (!I_RESETn)
		phase == 4'd3 |=> rom_addr[18:12] == {3'b000, TILE1_BASE})
		else $error("tile1 phase issued a foreign region");
	a_tile2_region: assert property (@(posedge W_CLK_12288M) disable iff (!I_RESETn)
		(phase == 4'd4 && !cfg_active) |=> rom_addr[18:12] == {3'b000, TILE2_BASE})
		else $error("tile2 phase issued a foreign region");
	a_obj1_region: assert property (@(posedge W_CLK_12288M) disable iff (!I_RESETn)
		phase == 4'd9 |=> rom_addr[18:12] == {3'b000, OBJ1_BASE})
		else $error("obj1 phase issued a foreign region");
	a_obj2_region: assert property (@(posedge W_CLK_12288M) disable iff (!I_RESETn)
		phase == 4'd10 |=> rom_addr[18:12] == {3'b000, OBJ2_BASE})
		else $error("obj2 phase issued a foreign region");
	a_obj3_region: assert property (@(posedge W_CLK_12288M) disable iff (!I_RESETn)
		phase == 4'd12 |=> rom_addr[18:12] == {3'b000, OBJ3_BASE})
		else $error("obj3 phase issued a foreign region");
	a_obj4_region: assert property (@(posedge W_CLK_12288M) disable iff (!I_RESETn)
		phase == 4'd13 |=> rom_addr[18:12] == {3'b000, OBJ4_BASE})
		else $error("obj4 phase issued a foreign region");

	// Loader owns the tile2 slot, no tile fetch while it runs
	a_cfg_borrow: assert property (@(posedge W_CLK_12288M) disable iff (!I_RESETn)
		(phase == 4'd4 && cfg_active) |=> rom_addr[18:13] == 6'b000111)
		else $error("config fetch overlapped a tile2 fetch");

	// One frame is 16 clocks
	a_frame_len: assert property (@(posedge W_CLK_12288M) disable iff (!I_RESETn)
		frame_end |=> !frame_end [*15] ##1 frame_end)
		else $error("frame_end period is not 16 cycles");

endmodule

//--- dv/rom_sound_tb.sv
`timescale 1ns/1ns

module rom_sound_tb import rom_share_pkg::*; ();

	logic              W_CLK_12288M;
	logic              I_RESETn;
	logic [ROM_AW-1:0] rom_addr;
	logic [BYTE_W-1:0] rom_data;
	logic [CPU_AW-1:0] cpu_addr;
	logic [GFX_AW-1:0] tile_addr;
	logic [GFX_AW-1:0] obj_addr;
	logic [BYTE_W-1:0] cpu_data, tile_data1, tile_data2;
	logic [BYTE_W-1:0] obj_data1, obj_data2, obj_data3, obj_data4;
	logic [3:0]        sound_trig;
	logic              walk_alt;
	logic [BYTE_W-1:0] digital_data;
	logic [BYTE_W-1:0] sound_out;
	logic [CFG_AW-1:0] cfg_addr;
	logic              cfg_we;
	cfg_target_e       cfg_target;
	logic              cfg_done;

	// Case table
	string       kinds[$];
	string       names[$];
	logic [31:0] arg0[$];
	logic [31:0] arg1[$];
	logic [31:0] expv[$];
	logic        loaded = 1'b0;
	longint      limit_ns;
	integer      seed = 32'h358a092b;

	tb_clock_gen clk_gen_i (.W_CLK_12288M(W_CLK_12288M), .I_RESETn(I_RESETn));

	rom_sound_top #(.CONF_COUNT(40)) rom_sound_top_i (
		.W_CLK_12288M(W_CLK_12288M), .I_RESETn(I_RESETn),
		.rom_addr(rom_addr), .rom_data(rom_data),
		.cpu_addr(cpu_addr), .cpu_data(cpu_data),
		.tile_addr(tile_addr), .tile_data1(tile_data1), .tile_data2(tile_data2),
		.obj_addr(obj_addr), .obj_data1(obj_data1), .obj_data2(obj_data2),
		.obj_data3(obj_data3), .obj_data4(obj_data4),
		.sound_trig(sound_trig), .walk_alt(walk_alt),
		.digital_data(digital_data), .sound_out(sound_out),
		.cfg_addr(cfg_addr), .cfg_we(cfg_we), .cfg_target(cfg_target), .cfg_done(cfg_done)
	);

	bind rom_slot_arbiter rom_sound_properties props_i (
		.W_CLK_12288M(W_CLK_12288M), .I_RESETn(I_RESETn), .phase(phase),
		.rom_addr(rom_addr), .cfg_active(cfg_active), .frame_end(frame_end)
	);

	// ROM model, answers in the same cycle
	function automatic logic [BYTE_W-1:0] rom_byte(input logic [ROM_AW-1:0] a);
		return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]};
	endfunction
	assign rom_data = rom_byte(rom_addr);

	// Table select of a config address
	function automatic cfg_target_e target_of(input logic [CFG_AW-1:0] a);
		if (!a[12])
			return CFG_SOUND;
		case (a[12:8])
			5'h10:   return CFG_COL0;
			5'h11:   return CFG_COL1;
			5'h12:   return CFG_VRAM;
			default: return CFG_SOUND;
		endcase
	endfunction

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input logic [BYTE_W-1:0] exp,
		input logic [BYTE_W-1:0] act);
		if (act !== exp)
			stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input logic [ROM_AW-1:0] exp,
		input logic [ROM_AW-1:0] act);
		if (act !== exp)
			stop_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_target(input string name, input cfg_target_e exp,
		input cfg_target_e act);
		if (act !== exp)
			stop_run($sformatf("mismatch %s expected %s actual %s", name, exp.name(),
				act.name()));
	endtask

	// Next drive point, just after the rising edge
	task automatic step();
		@(posedge W_CLK_12288M);
		#2;
	endtask

	task automatic idle_gap();
		int n;
		n = ($random(seed) & 7) + 1;
		repeat (n) step();
	endtask

	// ==================================================
	// Config load check
	// ==================================================
	task automatic run_cfg(input string name, input int count);
		int extra;
		int t;
		extra = 0;
		for (int i = 0; i < count; i++) begin
			t = 0;
			do begin
				@(negedge W_CLK_12288M);
				t++;
				if (t > 40)
					stop_run("no configuration write strobe within two frames");
			end while (!cfg_we);
			check_addr({name, "_addr"}, ROM_AW'(i), ROM_AW'(cfg_addr));
			check_byte({name, "_byte"}, rom_byte(ROM_AW'(19'h0E000 + i)), tile_data2);
			check_target({name, "_target"}, target_of(CFG_AW'(i)), cfg_target);
		end
		repeat (48) begin
			@(negedge W_CLK_12288M);
			if (cfg_we)
				extra++;
			if (!cfg_done)
				stop_run("cfg_done is not high after the configuration load");
		end
		check_byte({name, "_extra"}, 8'h00, BYTE_W'(extra));
	endtask

	// Phase 14 found by the obj4 address DFFF appearing on rom_addr
	task automatic align_phase14();
		int t;
		t = 0;
		do begin
			@(negedge W_CLK_12288M);
			t++;
		end while (rom_addr == 19'h0DFFF && t < 64);
		do begin
			@(negedge W_CLK_12288M);
			t++;
			if (t > 64)
				stop_run("rom_addr never showed the obj4 fetch used for alignment");
		end while (rom_addr != 19'h0DFFF);
	endtask

	// Pulse or raise a trigger in phase 15, return the first wave address
	task automatic fire_trigger(input int bit_no, input logic alt, input logic hold,
		output logic [ROM_AW-1:0] first);
		obj_addr = '1;
		align_phase14();
		align_phase14();
		step();
		sound_trig[bit_no] = 1'b1;
		walk_alt = alt;
		step();
		if (!hold)
			sound_trig[bit_no] = 1'b0;
		@(posedge W_CLK_12288M);
		@(negedge W_CLK_12288M);
		first = rom_addr;
	endtask

	task automatic sample_wave(output logic [ROM_AW-1:0] a);
		align_phase14();
		repeat (3) @(posedge W_CLK_12288M);
		@(negedge W_CLK_12288M);
		a = rom_addr;
	endtask

	task automatic run_case(input int k);
		logic [ROM_AW-1:0] a;
		logic [ROM_AW-1:0] b;
		logic [BYTE_W-1:0] got;
		case (kinds[k])
			"cfg": run_cfg(names[k], int'(expv[k]));
			"cpu": begin
				cpu_addr = arg0[k][CPU_AW-1:0];
				repeat (32) step();
				check_byte(names[k], expv[k][7:0], cpu_data);
			end
			"gfx": begin
				if (arg0[k] <= 2)
					tile_addr = arg1[k][GFX_AW-1:0];
				else
					obj_addr = arg1[k][GFX_AW-1:0];
				repeat (32) step();
				case (arg0[k])
					1:       got = tile_data1;
					2:       got = tile_data2;
					3:       got = obj_data1;
					4:       got = obj_data2;
					5:       got = obj_data3;
					default: got = obj_data4;
				endcase
				check_byte(names[k], expv[k][7:0], got);
			end
			"mix": begin
				digital_data = arg0[k][7:0];
				repeat (16) step();
				check_byte(names[k], expv[k][7:0], sound_out);
			end
			"walk": begin
				fire_trigger(WALK, arg0[k][0], 1'b0, a);
				check_addr(names[k], expv[k][ROM_AW-1:0], a);
			end
			"jump": begin
				fire_trigger(JUMP, walk_alt, 1'b0, a);
				check_addr(names[k], expv[k][ROM_AW-1:0], a);
			end
			"fall": begin
				fire_trigger(FALL, walk_alt, 1'b1, a);
				check_addr(names[k], expv[k][ROM_AW-1:0], a);
				repeat (32) step();
				sound_trig[FALL] = 1'b0;
				// Playback stops inside one sample time
				repeat (8) step();
				sample_wave(a);
				sample_wave(b);
				check_addr({names[k], "_stop"}, a, b);
			end
			default: stop_run($sformatf("unknown case kind %s in the case file", kinds[k]));
		endcase
	endtask

	task automatic load_cases();
		int    fd;
		int    r;
		string line;
		string k;
		string n;
		logic [31:0] x, y, e;
		fd = $fopen("dv/rom_sound_cases.txt", "r");
		if (fd == 0)
			stop_run("cannot open dv/rom_sound_cases.txt");
		while ($fgets(line, fd) > 0) begin
			if (line.len() == 0 || line[0] == 8'h23)
				continue;
			r = $sscanf(line, "%s %s %h %h %h", k, n, x, y, e);
			if (r == 5) begin
				kinds.push_back(k);
				names.push_back(n);
				arg0.push_back(x);
				arg1.push_back(y);
				expv.push_back(e);
			end else if (r > 0) begin
				stop_run("malformed line in the case file");
			end
		end
		$fclose(fd);
	endtask

	// Watchdog
	initial begin
		wait (loaded);
		#(limit_ns);
		$display("timeout after %0d ns with tests still running", limit_ns);
		$display("Simulation failed");
		$fatal(1);
	end

	// ==================================================
	// Main sequence
	// ==================================================
	initial begin
		cpu_addr     = '0;
		tile_addr    = '0;
		obj_addr     = '0;
		sound_trig   = '0;
		walk_alt     = 1'b0;
		digital_data = '0;
		load_cases();
		// 64 frames per case plus the config load
		limit_ns = longint'(kinds.size()) * 64 * 16 * 20 + (40 + 8) * 16 * 20;
		loaded = 1'b1;
		wait (I_RESETn);
		for (int k = 0; k < kinds.size(); k++) begin
			run_case(k);
			idle_gap();
		end
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS   = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic W_CLK_12288M,
	output logic I_RESETn
);

	// Free-running clock
	initial begin
		W_CLK_12288M = 1'b0;
		forever #(PERIOD_NS / 2) W_CLK_12288M = ~W_CLK_12288M;
	end

	// Reset held low over the first few edges
	initial begin
		I_RESETn = 1'b0;
		repeat (RESET_CYCLES) @(posedge W_CLK_12288M);
		#2 I_RESETn = 1'b1;
	end

endmodule

//--- rom_arbiter/rom_slot_arbiter.sv
`timescale 1ns/1ns

module rom_slot_arbiter import rom_share_pkg::*; (
	input  logic              W_CLK_12288M,
	input  logic              I_RESETn,
	input  logic [CPU_AW-1:0] cpu_addr,
	input  logic [GFX_AW-1:0] tile_addr,
	input  logic [GFX_AW-1:0] obj_addr,
	input  logic [ROM_AW-1:0] wave_addr,
	input  logic              cfg_active,
	input  logic [CFG_AW-1:0] cfg_addr,
	output logic [ROM_AW-1:0] rom_addr,
	input  logic [BYTE_W-1:0] rom_data,
	output logic [BYTE_W-1:0] cpu_data,
	output logic [BYTE_W-1:0] tile_data1,
	output logic [BYTE_W-1:0] tile_data2,
	output logic [BYTE_W-1:0] obj_data1,
	output logic [BYTE_W-1:0] obj_data2,
	output logic [BYTE_W-1:0] obj_data3,
	output logic [BYTE_W-1:0] obj_data4,
	output logic [BYTE_W-1:0] wave_data,
	output logic [BYTE_W-1:0] cfg_byte,
	output logic              frame_end
);

	localparam int PH_W = $clog2(PHASES);
	// Config bytes live at E000 and up
	localparam logic [2:0] CONF_REGION = 3'b111;

	logic [PH_W-1:0]   phase;
	slot_e             slot;
	slot_e             prev_slot;
	logic              cfg_slot;
	logic [ROM_AW-1:0] next_addr;

	// Swapped 2K program banks
	function automatic logic [ROM_AW-1:0] bank_remap(input logic [CPU_AW-1:0] a);
		logic [4:0] bank_in;
		logic [4:0] bank_out;
		bank_in = a[CPU_AW-1:11];
		case (bank_in)
			5'h02:   bank_out = 5'h06;
			5'h03:   bank_out = 5'h0B;
			5'h05:   bank_out = 5'h09;
			5'h06:   bank_out = 5'h02;
			5'h07:   bank_out = 5'h03;
			5'h09:   bank_out = 5'h05;
			5'h0B:   bank_out = 5'h07;
			default: bank_out = bank_in;
		endcase
		return ROM_AW'({bank_out, a[10:0]});
	endfunction

	// Region nibble on top of a graphics address
	function automatic logic [ROM_AW-1:0] region_addr(input logic [3:0] base,
		input logic [GFX_AW-1:0] a);
		return ROM_AW'({base, a});
	endfunction

	assign frame_end = (phase == PH_W'(PHASES - 1));

	// ==================================================
	// Owner of each phase
	// ==================================================
	always_comb begin
		case (phase)
			4'd0:                       slot = SLOT_WAVE;
			4'd2, 4'd5, 4'd8, 4'd11, 4'd15: slot = SLOT_CPU;
			4'd3:                       slot = SLOT_TILE1;
			4'd4:                       slot = SLOT_TILE2;
			4'd9:                       slot = SLOT_OBJ1;
			4'd10:                      slot = SLOT_OBJ2;
			4'd12:                      slot = SLOT_OBJ3;
			4'd13:                      slot = SLOT_OBJ4;
			default:                    slot = SLOT_IDLE;
		endcase
	end

	// Address of the slot owner
	always_comb begin
		case (slot)
			SLOT_WAVE:  next_addr = wave_addr;
			SLOT_CPU:   next_addr = bank_remap(cpu_addr);
			SLOT_TILE1: next_addr = region_addr(TILE1_BASE, tile_addr);
			// Loader borrows the second tile plane slot
			SLOT_TILE2: next_addr = cfg_active ? ROM_AW'({CONF_REGION, cfg_addr}) :
				region_addr(TILE2_BASE, tile_addr);
			SLOT_OBJ1:  next_addr = region_addr(OBJ1_BASE, obj_addr);
			SLOT_OBJ2:  next_addr = region_addr(OBJ2_BASE, obj_addr);
			SLOT_OBJ3:  next_addr = region_addr(OBJ3_BASE, obj_addr);
			SLOT_OBJ4:  next_addr = region_addr(OBJ4_BASE, obj_addr);
			default:    next_addr = rom_addr;
		endcase
	end

	// ==================================================
	// Address issue and data latch
	// ==================================================
	always_ff @(posedge W_CLK_12288M or negedge I_RESETn) begin
		if (!I_RESETn) begin
			phase      <= '0;
			prev_slot  <= SLOT_IDLE;
			cfg_slot   <= 1'b0;
			rom_addr   <= '0;
			cpu_data   <= '0;
			tile_data1 <= '0;
			tile_data2 <= '0;
			obj_data1  <= '0;
			obj_data2  <= '0;
			obj_data3  <= '0;
			obj_data4  <= '0;
			wave_data  <= '0;
			cfg_byte   <= '0;
		end else begin
			phase     <= frame_end ? '0 : phase + 1'b1;
			prev_slot <= slot;
			// Remember that the tile2 slot carried a config address
			cfg_slot  <= (slot == SLOT_TILE2) && cfg_active;
			rom_addr  <= next_addr;
			// ROM answers within the cycle, byte belongs to last owner
			case (prev_slot)
				SLOT_WAVE:  wave_data  <= rom_data;
				SLOT_CPU:   cpu_data   <= rom_data;
				SLOT_TILE1: tile_data1 <= rom_data;
				SLOT_TILE2: begin
					tile_data2 <= rom_data;
					if (cfg_slot)
						cfg_byte <= rom_data;
				end
				SLOT_OBJ1:  obj_data1  <= rom_data;
				SLOT_OBJ2:  obj_data2  <= rom_data;
				SLOT_OBJ3:  obj_data3  <= rom_data;
				SLOT_OBJ4:  obj_data4  <= rom_data;
				default: ;
			endcase
		end
	end

endmodule

//--- rtl/config_loader.sv
`timescale 1ns/1ns

module config_loader import rom_share_pkg::*; #(
	parameter int CONF_COUNT = CONF_LAST + 1
) (
	input  logic              W_CLK_12288M,
	input  logic              I_RESETn,
	input  logic              frame_end,
	input  logic [BYTE_W-1:0] cfg_byte,
	output logic              cfg_active,
	output logic [CFG_AW-1:0] cfg_addr,
	output logic              cfg_we,
	output cfg_target_e       cfg_target,
	output logic              cfg_done,
	output logic [BYTE_W-1:0] cfg_wdata
);

	logic last_addr;

	assign cfg_active = ~cfg_done;
	assign last_addr  = (cfg_addr == CFG_AW'(CONF_COUNT - 1));
	// Byte for the strobe, latched once per frame by the arbiter
	assign cfg_wdata  = cfg_byte;

	// Table select from address bits 12..8
	always_comb begin
		if (cfg_addr[CFG_AW-1] == CONF_SOUND_TOP)
			cfg_target = CFG_SOUND;
		else if (cfg_addr[CFG_AW-1:8] == CONF_COL0)
			cfg_target = CFG_COL0;
		else if (cfg_addr[CFG_AW-1:8] == CONF_COL1)
			cfg_target = CFG_COL1;
		else if (cfg_addr[CFG_AW-1:8] == CONF_VRAM)
			cfg_target = CFG_VRAM;
		else
			cfg_target = CFG_SOUND;
	end

	// ==================================================
	// One write per frame
	// ==================================================
	always_ff @(posedge W_CLK_12288M or negedge I_RESETn) begin
		if (!I_RESETn) begin
			cfg_addr <= '0;
			cfg_we   <= 1'b0;
			cfg_done <= 1'b0;
		end else begin
			// Strobe right after phase 15
			cfg_we <= frame_end && !cfg_done;
			// Step the address once the strobe is out
			if (cfg_we) begin
				if (last_addr)
					cfg_done <= 1'b1;
				else
					cfg_addr <= cfg_addr + 1'b1;
			end
		end
	end

endmodule

//--- rtl/rom_sound_top.sv
`timescale 1ns/1ns

module rom_sound_top import rom_share_pkg::*; #(
	parameter int SAMPLE_DIV = 4,
	parameter int CONF_COUNT = CONF_LAST + 1
) (
	input  logic              W_CLK_12288M,
	input  logic              I_RESETn,
	output logic [ROM_AW-1:0] rom_addr,
	input  logic [BYTE_W-1:0] rom_data,
	input  logic [CPU_AW-1:0] cpu_addr,
	output logic [BYTE_W-1:0] cpu_data,
	input  logic [GFX_AW-1:0] tile_addr,
	output logic [BYTE_W-1:0] tile_data1,
	output logic [BYTE_W-1:0] tile_data2,
	input  logic [GFX_AW-1:0] obj_addr,
	output logic [BYTE_W-1:0] obj_data1,
	output logic [BYTE_W-1:0] obj_data2,
	output logic [BYTE_W-1:0] obj_data3,
	output logic [BYTE_W-1:0] obj_data4,
	input  logic [3:0]        sound_trig,
	input  logic              walk_alt,
	input  logic [BYTE_W-1:0] digital_data,
	output logic [BYTE_W-1:0] sound_out,
	output logic [CFG_AW-1:0] cfg_addr,
	output logic              cfg_we,
	output cfg_target_e       cfg_target,
	output logic              cfg_done
);

	logic [ROM_AW-1:0] wave_addr;
	logic [BYTE_W-1:0] wave_data;
	logic              playing;
	logic              cfg_active;
	logic [BYTE_W-1:0] cfg_byte;
	logic              frame_end;

	// ==================================================
	// Shared ROM bus
	// ==================================================
	rom_slot_arbiter rom_slot_arbiter_i (
		.W_CLK_12288M (W_CLK_12288M),
		.I_RESETn     (I_RESETn),
		.cpu_addr     (cpu_addr),
		.tile_addr    (tile_addr),
		.obj_addr     (obj_addr),
		.wave_addr    (wave_addr),
		.cfg_active   (cfg_active),
		.cfg_addr     (cfg_addr),
		.rom_addr     (rom_addr),
		.rom_data     (rom_data),
		.cpu_data     (cpu_data),
		.tile_data1   (tile_data1),
		.tile_data2   (tile_data2),
		.obj_data1    (obj_data1),
		.obj_data2    (obj_data2),
		.obj_data3    (obj_data3),
		.obj_data4    (obj_data4),
		.wave_data    (wave_data),
		.cfg_byte     (cfg_byte),
		.frame_end    (frame_end)
	);

	// Start-up table copy
	config_loader #(
		.CONF_COUNT (CONF_COUNT)
	) config_loader_i (
		.W_CLK_12288M (W_CLK_12288M),
		.I_RESETn     (I_RESETn),
		.frame_end    (frame_end),
		.cfg_byte     (cfg_byte),
		.cfg_active   (cfg_active),
		.cfg_addr     (cfg_addr),
		.cfg_we       (cfg_we),
		.cfg_target   (cfg_target),
		.cfg_done     (cfg_done),
		.cfg_wdata    ()
	);

	// Sound path
	wave_sample_player #(
		.SAMPLE_DIV (SAMPLE_DIV)
	) wave_sample_player_i (
		.W_CLK_12288M (W_CLK_12288M),
		.I_RESETn     (I_RESETn),
		.sound_trig   (sound_trig),
		.walk_alt     (walk_alt),
		.wave_addr    (wave_addr),
		.playing      (playing)
	);

	sound_mixer sound_mixer_i (
		.W_CLK_12288M (W_CLK_12288M),
		.I_RESETn     (I_RESETn),
		.wave_data    (wave_data),
		.digital_data (digital_data),
		.playing      (playing),
		.sound_out    (sound_out)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# Compile and run the ROM sharing testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module rom_sound_tb -f sim.f -o Vrom_sound_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/Vrom_sound_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Simulation failed" "$LOG"; then
	echo "run failed"
	exit 1
fi

if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi

echo "run passed"
exit 0

//--- sim.f
common/rom_share_pkg.sv
rom_arbiter/rom_slot_arbiter.sv
rtl/config_loader.sv
sound/wave_sample_player.sv
sound/sound_mixer.sv
rtl/rom_sound_top.sv
dv/tb_clock_gen.sv
dv/rom_sound_properties.sv
dv/rom_sound_tb.sv

//--- sound/sound_mixer.sv
`timescale 1ns/1ns

module sound_mixer import rom_share_pkg::*; (
	input  logic              W_CLK_12288M,
	input  logic              I_RESETn,
	input  logic [BYTE_W-1:0] wave_data,
	input  logic [BYTE_W-1:0] digital_data,
	input  logic              playing,
	output logic [BYTE_W-1:0] sound_out
);

	// Unsigned midpoint, silence for the wave channel
	localparam logic [BYTE_W-1:0] SILENCE = 8'h80;

	logic [BYTE_W-1:0] wave_in;
	logic [BYTE_W:0]   sound_mix;
	logic [BYTE_W:0]   mix_shift;

	assign wave_in   = playing ? wave_data : SILENCE;
	// Both inputs offset binary, sum is 9 bits
	assign sound_mix = {1'b0, wave_in} + {1'b0, digital_data};
	// Remove one midpoint
	assign mix_shift = sound_mix - MIX_LO;

	// ==================================================
	// Limiter
	// ==================================================
	always_ff @(posedge W_CLK_12288M or negedge I_RESETn) begin
		if (!I_RESETn) begin
			sound_out <= '0;
		end else begin
			if (sound_mix >= MIX_HI)
				// Top clip
				sound_out <= '1;
			else if (sound_mix <= MIX_LO)
				// Bottom clip
				sound_out <= '0;
			else
				sound_out <= mix_shift[BYTE_W-1:0];
		end
	end

endmodule

//--- sound/wave_sample_player.sv
`timescale 1ns/1ns

module wave_sample_player import rom_share_pkg::*; #(
	parameter int SAMPLE_DIV = 4
) (
	input  logic              W_CLK_12288M,
	input  logic              I_RESETn,
	input  logic [3:0]        sound_trig,
	input  logic              walk_alt,
	output logic [ROM_AW-1:0] wave_addr,
	output logic              playing
);

	localparam int DIV_W = $clog2(SAMPLE_DIV + 1);

	logic [3:0]       trig_d;
	logic [3:0]       trig_rise;
	logic [2:0]       seq_idx;
	logic [2:0]       walk_slot;
	WAVE_BASE_e       start_snd;
	WAVE_BASE_e       cur_snd;
	logic [15:0]      start_addr;
	logic [15:0]      samp_addr;
	logic [15:0]      samp_left;
	logic [DIV_W-1:0] div_cnt;
	logic             sample_tick;

	assign trig_rise   = sound_trig & ~trig_d;
	assign sample_tick = (div_cnt == DIV_W'(SAMPLE_DIV - 1));
	// Climb samples sit three slots past the walk ones
	assign walk_slot   = walk_alt ? MSAMPLE_SEQ[seq_idx] : MSAMPLE_SEQ[seq_idx] + 3'd3;
	assign wave_addr   = ROM_AW'(samp_addr);

	// ==================================================
	// Start selection
	// ==================================================
	always_comb begin
		// Fall wins over land, land over jump
		if (trig_rise[FALL])
			start_snd = FALL;
		else if (trig_rise[LAND])
			start_snd = LAND;
		else if (trig_rise[JUMP])
			start_snd = JUMP;
		else
			start_snd = WALK;
		start_addr = WAVE_START[start_snd];
		// Walk start is slot times 2K
		if (start_snd == WALK)
			start_addr = start_addr + {2'b00, walk_slot, 11'h000};
	end

	always_ff @(posedge W_CLK_12288M or negedge I_RESETn) begin
		if (!I_RESETn) begin
			trig_d    <= '0;
			seq_idx   <= '0;
			cur_snd   <= WALK;
			samp_addr <= '0;
			samp_left <= '0;
			div_cnt   <= '0;
			playing   <= 1'b0;
		end else begin
			trig_d <= sound_trig;
			// Seven-step multi-sample pattern
			if (trig_rise[WALK])
				seq_idx <= (seq_idx == 3'd6) ? 3'd0 : seq_idx + 3'd1;
			if (|trig_rise) begin
				cur_snd   <= start_snd;
				samp_addr <= start_addr;
				samp_left <= WAVE_LEN[start_snd];
				div_cnt   <= '0;
				playing   <= 1'b1;
			end else if (playing && cur_snd == FALL && !sound_trig[FALL]) begin
				// Fall is cut as soon as the trigger goes away
				playing <= 1'b0;
			end else if (playing) begin
				if (sample_tick) begin
					div_cnt <= '0;
					if (samp_left == 16'd1) begin
						playing <= 1'b0;
					end else begin
						samp_addr <= samp_addr + 16'd1;
						samp_left <= samp_left - 16'd1;
					end
				end else begin
					div_cnt <= div_cnt + 1'b1;
				end
			end
		end
	end

endmodule
